// ==== rtl/via_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VIA register map and sizes
// Register select numbers and datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VIA_DEFINES_SVH
`define VIA_DEFINES_SVH

// Register select numbers, slot 10 (shift register) reads zero
`define VIA_RS_ORB    4'd0
`define VIA_RS_ORA    4'd1
`define VIA_RS_DDRB   4'd2
`define VIA_RS_DDRA   4'd3
`define VIA_RS_T1CL   4'd4
`define VIA_RS_T1CH   4'd5
`define VIA_RS_T1LL   4'd6
`define VIA_RS_T1LH   4'd7
`define VIA_RS_T2CL   4'd8
`define VIA_RS_T2CH   4'd9
`define VIA_RS_ACR    4'd11
`define VIA_RS_PCR    4'd12
`define VIA_RS_IFR    4'd13
`define VIA_RS_IER    4'd14
`define VIA_RS_ORA_NH 4'd15

`define VIA_TIMER_W 16
`define VIA_FLAGS   7

`endif

// ==== rtl/viaPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VIA shared types
// Bundles passed between the register file, timers
// and interrupt logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "via_defines.svh"

package viaPkg;

	// One CPU access as seen on the bus phase
	typedef struct packed {
		logic       cs;
		logic       rnw;
		logic [3:0] rs;
		logic [7:0] wdata;
	} busReq_t;

	// Decoded accesses, already qualified by clkEn
	typedef struct packed {
		logic       t1LoRead;
		logic       t1HiWrite;
		logic       t1LatchWrite;
		logic       t1LatchHiWrite;
		logic       t2LoRead;
		logic       t2LoWrite;
		logic       t2HiWrite;
		logic       portAAccess;
		logic       portBAccess;
		logic       ifrWrite;
		logic       ierWrite;
		logic [7:0] wdata;
	} accessStrobes_t;

	typedef struct packed {
		logic [7:0] acr;
		logic [7:0] pcr;
	} viaCtrl_t;

	typedef struct packed {
		logic [`VIA_TIMER_W-1:0] t1Count;
		logic [`VIA_TIMER_W-1:0] t1Latch;
		logic [`VIA_TIMER_W-1:0] t2Count;
		logic                    pb7;
	} timerState_t;

	// Single-cycle expiry pulses
	typedef struct packed {
		logic t1Expired;
		logic t2Expired;
	} timerEvents_t;

	typedef struct packed {
		logic [`VIA_FLAGS-1:0] ifr;
		logic [`VIA_FLAGS-1:0] ier;
		logic [7:0]            latchA;
		logic [7:0]            latchB;
	} irqState_t;

endpackage

`default_nettype wire

// ==== rtl/viaRegisterFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VIA register file
// Decodes bus accesses, holds port, direction and
// control registers and drives the read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "via_defines.svh"

module viaRegisterFile (
	input  logic                   CLK,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  viaPkg::busReq_t        bus,
	input  logic [7:0]             portAIn,
	input  logic [7:0]             portBIn,
	input  viaPkg::timerState_t    timers,
	input  viaPkg::irqState_t      irq,
	output viaPkg::accessStrobes_t strobes,
	output viaPkg::viaCtrl_t       ctrl,
	output logic [7:0]             dataOut,
	output logic [7:0]             portAOut,
	output logic [7:0]             portADir,
	output logic [7:0]             portBOut,
	output logic [7:0]             portBDir
);

	logic [7:0] ora;
	logic [7:0] orb;
	logic [7:0] ddra;
	logic [7:0] ddrb;
	logic [7:0] acr;
	logic [7:0] pcr;
	logic       access;
	logic       wr;
	logic       rd;
	logic [7:0] inA;
	logic [7:0] inB;

	assign access = clkEn & bus.cs;
	assign wr     = access & ~bus.rnw;
	assign rd     = access & bus.rnw;

	// Strobes for the timer and interrupt blocks
	assign strobes.t1LoRead       = rd & (bus.rs == `VIA_RS_T1CL);
	assign strobes.t1HiWrite      = wr & (bus.rs == `VIA_RS_T1CH);
	assign strobes.t1LatchWrite   = wr & ((bus.rs == `VIA_RS_T1CL) | (bus.rs == `VIA_RS_T1LL));
	assign strobes.t1LatchHiWrite = wr & (bus.rs == `VIA_RS_T1LH);
	assign strobes.t2LoRead       = rd & (bus.rs == `VIA_RS_T2CL);
	assign strobes.t2LoWrite      = wr & (bus.rs == `VIA_RS_T2CL);
	assign strobes.t2HiWrite      = wr & (bus.rs == `VIA_RS_T2CH);
	// The no-handshake alias of ORA leaves the flags alone
	assign strobes.portAAccess    = access & (bus.rs == `VIA_RS_ORA);
	assign strobes.portBAccess    = access & (bus.rs == `VIA_RS_ORB);
	assign strobes.ifrWrite       = wr & (bus.rs == `VIA_RS_IFR);
	assign strobes.ierWrite       = wr & (bus.rs == `VIA_RS_IER);
	assign strobes.wdata          = bus.wdata;

	// Direction and control registers
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			ddra <= 8'h00;
			ddrb <= 8'h00;
			acr  <= 8'h00;
			pcr  <= 8'h00;
		end else if (wr) begin
			case (bus.rs)
				`VIA_RS_DDRA: ddra <= bus.wdata;
				`VIA_RS_DDRB: ddrb <= bus.wdata;
				`VIA_RS_ACR:  acr  <= bus.wdata;
				`VIA_RS_PCR:  pcr  <= bus.wdata;
				default: ;
			endcase
		end
	end

	// Output data registers
	always_ff @(posedge CLK) begin
		if (wr) begin
			if ((bus.rs == `VIA_RS_ORA) || (bus.rs == `VIA_RS_ORA_NH))
				ora <= bus.wdata;
			if (bus.rs == `VIA_RS_ORB)
				orb <= bus.wdata;
		end
	end

	assign ctrl.acr = acr;
	assign ctrl.pcr = pcr;

	// PB7 taken over by timer 1 when ACR bit 7 is set
	assign portAOut = ora;
	assign portADir = ddra;
	assign portBOut = {acr[7] ? timers.pb7 : orb[7], orb[6:0]};
	assign portBDir = {acr[7] | ddrb[7], ddrb[6:0]};

	// Latched or live input
	assign inA = acr[0] ? irq.latchA : portAIn;
	assign inB = acr[1] ? irq.latchB : portBIn;

	always_comb begin
		dataOut = 8'h00;
		if (bus.cs && bus.rnw) begin
			case (bus.rs)
				`VIA_RS_ORB:    dataOut = (orb & ddrb) | (inB & ~ddrb);
				`VIA_RS_ORA,
				`VIA_RS_ORA_NH: dataOut = inA;
				`VIA_RS_DDRB:   dataOut = ddrb;
				`VIA_RS_DDRA:   dataOut = ddra;
				`VIA_RS_T1CL:   dataOut = timers.t1Count[7:0];
				`VIA_RS_T1CH:   dataOut = timers.t1Count[15:8];
				`VIA_RS_T1LL:   dataOut = timers.t1Latch[7:0];
				`VIA_RS_T1LH:   dataOut = timers.t1Latch[15:8];
				`VIA_RS_T2CL:   dataOut = timers.t2Count[7:0];
				`VIA_RS_T2CH:   dataOut = timers.t2Count[15:8];
				`VIA_RS_ACR:    dataOut = acr;
				`VIA_RS_PCR:    dataOut = pcr;
				// Bit 7 mirrors the request line
				`VIA_RS_IFR:    dataOut = {|(irq.ifr & irq.ier), irq.ifr};
				`VIA_RS_IER:    dataOut = {1'b1, irq.ier};
				default:        dataOut = 8'h00;
			endcase
		end
	end

	// A direction write shows on the pins from the next edge
	assert property (@(posedge CLK) disable iff (!nRESET)
		(wr && (bus.rs == `VIA_RS_DDRA)) |=> (portADir == $past(bus.wdata)));

endmodule

`default_nettype wire

// ==== rtl/viaTimers.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VIA timers
// Timer 1 with latch, one-shot/free-run and PB7,
// timer 2 as a one-shot down counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "via_defines.svh"

module viaTimers (
	input  logic                   CLK,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  viaPkg::accessStrobes_t strobes,
	input  viaPkg::viaCtrl_t       ctrl,
	output viaPkg::timerState_t    state,
	output viaPkg::timerEvents_t   events
);

	localparam logic [`VIA_TIMER_W-1:0] countStep = 1;

	logic [`VIA_TIMER_W-1:0] t1Count;
	logic [`VIA_TIMER_W-1:0] t1Latch;
	logic [`VIA_TIMER_W-1:0] t2Count;
	logic [7:0]              t2LatchLo;
	logic                    t1Armed;
	logic                    t2Armed;
	logic                    pb7;
	logic                    freeRun;
	logic                    t1Zero;
	logic                    t2Zero;
	logic                    t1Fire;
	logic                    t2Fire;
	logic                    t1ShotDone;

	assign freeRun = ctrl.acr[6];
	assign t1Zero  = (t1Count == '0);
	assign t2Zero  = (t2Count == '0);

	// Free-run fires on every zero, one-shot only once per load
	assign t1Fire = clkEn & t1Zero & ~strobes.t1HiWrite & (t1Armed | freeRun);
	assign t2Fire = clkEn & t2Zero & ~strobes.t2HiWrite & t2Armed;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			t1Count <= '0;
			t1Latch <= '0;
			t1Armed <= 1'b0;
		end else if (clkEn) begin
			if (strobes.t1LatchWrite)
				t1Latch[7:0] <= strobes.wdata;
			if (strobes.t1LatchHiWrite)
				t1Latch[15:8] <= strobes.wdata;
			if (strobes.t1HiWrite) begin
				t1Latch[15:8] <= strobes.wdata;
				t1Count       <= {strobes.wdata, t1Latch[7:0]};
				t1Armed       <= 1'b1;
			end else if (t1Zero) begin
				// Reload from the latch at every zero
				t1Count <= t1Latch;
				if (t1Fire)
					t1Armed <= 1'b0;
			end else begin
				t1Count <= t1Count - countStep;
			end
		end
	end

	// PB7 idles high, drops on a one-shot load
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			pb7 <= 1'b1;
		end else if (clkEn) begin
			if (strobes.t1HiWrite && !freeRun)
				pb7 <= 1'b0;
			else if (t1Fire)
				pb7 <= freeRun ? ~pb7 : 1'b1;
		end
	end

	// Timer 2 keeps counting past zero without reload
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			t2Count   <= '0;
			t2LatchLo <= 8'h00;
			t2Armed   <= 1'b0;
		end else if (clkEn) begin
			if (strobes.t2LoWrite)
				t2LatchLo <= strobes.wdata;
			if (strobes.t2HiWrite) begin
				t2Count <= {strobes.wdata, t2LatchLo};
				t2Armed <= 1'b1;
			end else begin
				t2Count <= t2Count - countStep;
				if (t2Fire)
					t2Armed <= 1'b0;
			end
		end
	end

	assign state.t1Count = t1Count;
	assign state.t1Latch = t1Latch;
	assign state.t2Count = t2Count;
	assign state.pb7     = pb7;

	assign events.t1Expired = t1Fire;
	assign events.t2Expired = t2Fire;

	// Remembers a one-shot expiry since the last T1CH write
	always_ff @(posedge CLK) begin
		if (!nRESET)
			t1ShotDone <= 1'b0;
		else if (strobes.t1HiWrite)
			t1ShotDone <= 1'b0;
		else if (t1Fire && !freeRun)
			t1ShotDone <= 1'b1;
	end

	assert property (@(posedge CLK) disable iff (!nRESET)
		(t1Fire && !freeRun) |-> !t1ShotDone);

endmodule

`default_nettype wire

// ==== rtl/viaInterrupts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VIA interrupt logic
// Control-line edges, port input latches and the
// flag/enable registers behind the request line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "via_defines.svh"

module viaInterrupts (
	input  logic                   CLK,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  logic                   ca1,
	input  logic                   ca2,
	input  logic                   cb1,
	input  logic                   cb2,
	input  logic [7:0]             portAIn,
	input  logic [7:0]             portBIn,
	input  viaPkg::accessStrobes_t strobes,
	input  viaPkg::viaCtrl_t       ctrl,
	input  viaPkg::timerEvents_t   events,
	input  logic                   cs,
	output viaPkg::irqState_t      irq,
	output logic                   nIrq
);

	logic [3:0]            ctlNow;
	logic [3:0]            ctlPrev;
	logic [3:0]            ctlPol;
	logic [3:0]            ctlEdge;
	logic                  sampleEn;
	logic [`VIA_FLAGS-1:0] flagSet;
	logic [`VIA_FLAGS-1:0] flagClr;
	logic [`VIA_FLAGS-1:0] ifr;
	logic [`VIA_FLAGS-1:0] ier;
	logic [7:0]            latchA;
	logic [7:0]            latchB;

	// Lines are only looked at outside CPU accesses
	assign sampleEn = clkEn & ~cs;
	assign ctlNow   = {cb2, cb1, ca2, ca1};

	// CA2 and CB2 count falling edges only
	assign ctlPol  = {1'b0, ctrl.pcr[4], 1'b0, ctrl.pcr[0]};
	assign ctlEdge = sampleEn ?
		((ctlPol & ctlNow & ~ctlPrev) | (~ctlPol & ~ctlNow & ctlPrev)) : 4'b0000;

	// Previous sample holds across accesses, so late edges still count
	always_ff @(posedge CLK) begin
		if (!nRESET)
			ctlPrev <= ctlNow;
		else if (sampleEn)
			ctlPrev <= ctlNow;
	end

	// Input latching on the CA1/CB1 edge
	always_ff @(posedge CLK) begin
		if (ctlEdge[0] && ctrl.acr[0])
			latchA <= portAIn;
		if (ctlEdge[2] && ctrl.acr[1])
			latchB <= portBIn;
	end

	// Flag order is T1, T2, CB1, CB2, SR, CA1, CA2
	assign flagSet = {events.t1Expired, events.t2Expired, ctlEdge[2], ctlEdge[3],
		1'b0, ctlEdge[0], ctlEdge[1]};

	assign flagClr = {strobes.t1LoRead | strobes.t1HiWrite,
		strobes.t2LoRead | strobes.t2HiWrite,
		strobes.portBAccess, strobes.portBAccess, 1'b0,
		strobes.portAAccess, strobes.portAAccess}
		| (strobes.ifrWrite ? strobes.wdata[`VIA_FLAGS-1:0] : '0);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			ifr <= '0;
			ier <= '0;
		end else if (clkEn) begin
			// A new event wins over a clear in the same phase
			ifr <= (ifr & ~flagClr) | flagSet;
			if (strobes.ierWrite) begin
				if (strobes.wdata[7])
					ier <= ier | strobes.wdata[`VIA_FLAGS-1:0];
				else
					ier <= ier & ~strobes.wdata[`VIA_FLAGS-1:0];
			end
		end
	end

	assign nIrq = ~|(ifr & ier);

	assign irq.ifr    = ifr;
	assign irq.ier    = ier;
	assign irq.latchA = latchA;
	assign irq.latchB = latchB;

	// An enabled event pulls the request low at the next edge
	assert property (@(posedge CLK) disable iff (!nRESET)
		(clkEn && !strobes.ierWrite && |(flagSet & ier)) |=> !nIrq);

endmodule

`default_nettype wire

// ==== rtl/via6522.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 6522-style versatile interface adapter
// Forms the chip select and ties the register file,
// timers and interrupt logic together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module via6522 (
	input  logic       CLK,
	input  logic       nRESET,
	input  logic       clkEn,
	input  logic       cs1,
	input  logic       nCs2,
	input  logic       rnw,
	input  logic [3:0] rs,
	input  logic [7:0] dataIn,
	output logic [7:0] dataOut,
	input  logic       ca1,
	input  logic       ca2,
	input  logic       cb1,
	input  logic       cb2,
	input  logic [7:0] portAIn,
	output logic [7:0] portAOut,
	output logic [7:0] portADir,
	input  logic [7:0] portBIn,
	output logic [7:0] portBOut,
	output logic [7:0] portBDir,
	output logic       nIrq
);

	viaPkg::busReq_t        bus;
	viaPkg::accessStrobes_t strobes;
	viaPkg::viaCtrl_t       ctrl;
	viaPkg::timerState_t    timerState;
	viaPkg::timerEvents_t   timerEvents;
	viaPkg::irqState_t      irqState;

	assign bus.cs    = cs1 & ~nCs2;
	assign bus.rnw   = rnw;
	assign bus.rs    = rs;
	assign bus.wdata = dataIn;

	viaRegisterFile i_regs (
		.CLK      (CLK),
		.nRESET   (nRESET),
		.clkEn    (clkEn),
		.bus      (bus),
		.portAIn  (portAIn),
		.portBIn  (portBIn),
		.timers   (timerState),
		.irq      (irqState),
		.strobes  (strobes),
		.ctrl     (ctrl),
		.dataOut  (dataOut),
		.portAOut (portAOut),
		.portADir (portADir),
		.portBOut (portBOut),
		.portBDir (portBDir)
	);

	viaTimers i_timers (
		.CLK     (CLK),
		.nRESET  (nRESET),
		.clkEn   (clkEn),
		.strobes (strobes),
		.ctrl    (ctrl),
		.state   (timerState),
		.events  (timerEvents)
	);

	viaInterrupts i_irq (
		.CLK     (CLK),
		.nRESET  (nRESET),
		.clkEn   (clkEn),
		.ca1     (ca1),
		.ca2     (ca2),
		.cb1     (cb1),
		.cb2     (cb2),
		.portAIn (portAIn),
		.portBIn (portBIn),
		.strobes (strobes),
		.ctrl    (ctrl),
		.events  (timerEvents),
		.cs      (bus.cs),
		.irq     (irqState),
		.nIrq    (nIrq)
	);

endmodule

`default_nettype wire

// ==== dv/tbVia.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VIA testbench
// Random register, edge and timer traffic checked
// against a small model of ports and flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "via_defines.svh"

module tbVia;
	timeunit 1ns;
	timeprecision 1ps;

	// 200 accesses at up to 4 cycles each, 3 timer loads
	localparam int cycleLimit = 200 * 4 + 3 * 300;

	logic CLK, nRESET, clkEn, cs1, nCs2, rnw;
	logic [3:0] rs;
	logic [7:0] dataIn, dataOut;
	logic ca1, ca2, cb1, cb2;
	logic [7:0] portAIn, portAOut, portADir, portBIn, portBOut, portBDir;
	logic nIrq;

	integer seed = 3;
	int cycles = 0;
	logic [6:0] mIfr, mIer;
	logic [3:0] lines;
	logic [7:0] pinA, pinB;
	logic [7:0] rd, ora, orb, ddra, ddrb, pcr;

	via6522 i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic checkIrq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: nIrq got %b expected %b", $time, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic checkTimerFlag(input string name, input logic seen, input int taken,
		input int limit);
		if (!seen) begin
			$display("CHECK FAILED at %0t: %s got no flag after %0d clkEn expected by %0d",
				$time, name, taken, limit);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// One bus cycle with clkEn high, read data sampled mid-phase
	task automatic access(input logic r, input logic [3:0] sel, input logic [7:0] d,
		output logic [7:0] q);
		@(negedge CLK);
		clkEn = 1'b1;
		cs1 = 1'b1;
		rnw = r;
		rs = sel;
		dataIn = d;
		portAIn = pinA;
		portBIn = pinB;
		#2 q = dataOut;
		@(posedge CLK);
		#1;
	endtask

	task automatic write(input logic [3:0] sel, input logic [7:0] d);
		logic [7:0] unused;
		access(1'b0, sel, d, unused);
	endtask

	// Idle cycle, chip deselected, control lines driven
	task automatic idle(input logic en);
		@(negedge CLK);
		clkEn = en;
		cs1 = 1'b0;
		rnw = 1'b1;
		{cb2, cb1, ca2, ca1} = lines;
		portAIn = pinA;
		portBIn = pinB;
		@(posedge CLK);
		#1;
	endtask

	function automatic logic [7:0] ifrRead();
		return {|(mIfr & mIer), mIfr};
	endfunction

	task automatic waitTimerFlag(input string name, input int n);
		int taken;
		logic seen;
		taken = 0;
		seen = 1'b0;
		while (!seen && taken < n + 3) begin
			idle(1'($random(seed)));
			if (clkEn)
				taken++;
			seen = (nIrq === 1'b0);
		end
		checkTimerFlag(name, seen, taken, n + 3);
	endtask

	initial begin
		int n;
		int k;
		logic [3:0] oldLines;
		logic [3:0] rise;
		logic [3:0] fall;
		logic [7:0] v;
		logic pb7;
		nRESET = 1'b0;
		clkEn = 1'b0;
		cs1 = 1'b0;
		nCs2 = 1'b0;
		rnw = 1'b1;
		rs = 4'd0;
		dataIn = 8'h00;
		lines = 4'b0000;
		{cb2, cb1, ca2, ca1} = lines;
		pinA = 8'h00;
		pinB = 8'h00;
		portAIn = 8'h00;
		portBIn = 8'h00;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		nRESET = 1'b1;

		// Reset values
		access(1'b1, `VIA_RS_IFR, 8'h00, rd);
		checkByte("IFR", rd, 8'h00);
		access(1'b1, `VIA_RS_IER, 8'h00, rd);
		checkByte("IER", rd, 8'h80);
		access(1'b1, `VIA_RS_ACR, 8'h00, rd);
		checkByte("ACR", rd, 8'h00);
		access(1'b1, `VIA_RS_PCR, 8'h00, rd);
		checkByte("PCR", rd, 8'h00);
		access(1'b1, `VIA_RS_DDRA, 8'h00, rd);
		checkByte("DDRA", rd, 8'h00);
		access(1'b1, `VIA_RS_DDRB, 8'h00, rd);
		checkByte("DDRB", rd, 8'h00);
		checkIrq(nIrq, 1'b1);
		checkByte("portADir", portADir, 8'h00);
		checkByte("portBDir", portBDir, 8'h00);

		// Ports and direction registers
		for (k = 0; k < 20; k++) begin
			ora = $random(seed);
			orb = $random(seed);
			ddra = $random(seed);
			ddrb = $random(seed);
			pinA = $random(seed);
			pinB = $random(seed);
			write(`VIA_RS_ORA, ora);
			write(`VIA_RS_ORB, orb);
			write(`VIA_RS_DDRA, ddra);
			write(`VIA_RS_DDRB, ddrb);
			checkByte("portAOut", portAOut, ora);
			checkByte("portBOut", portBOut, orb);
			checkByte("portADir", portADir, ddra);
			checkByte("portBDir", portBDir, ddrb);
			access(1'b1, `VIA_RS_ORB, 8'h00, rd);
			checkByte("ORB read", rd, (orb & ddrb) | (pinB & ~ddrb));
			access(1'b1, `VIA_RS_ORA, 8'h00, rd);
			checkByte("ORA read", rd, pinA);
		end

		// Edge flags, enables and clears
		mIfr = '0;
		mIer = '0;
		for (k = 0; k < 40; k++) begin
			pcr = $random(seed);
			write(`VIA_RS_PCR, pcr);
			v = $random(seed);
			write(`VIA_RS_IER, v);
			mIer = v[7] ? (mIer | v[6:0]) : (mIer & ~v[6:0]);
			oldLines = lines;
			lines[$unsigned($random(seed)) % 4] = 1'($random(seed));
			idle(1'b1);
			rise = lines & ~oldLines;
			fall = oldLines & ~lines;
			// CA1 and CB1 polarity from PCR
			if (pcr[0] ? rise[0] : fall[0])
				mIfr[1] = 1'b1;
			if (pcr[4] ? rise[2] : fall[2])
				mIfr[4] = 1'b1;
			// CA2 and CB2 only flag falling edges
			if (fall[1])
				mIfr[0] = 1'b1;
			if (fall[3])
				mIfr[3] = 1'b1;
			checkIrq(nIrq, ~|(mIfr & mIer));
			case ($unsigned($random(seed)) % 4)
				0: begin
					access(1'b1, `VIA_RS_ORA, 8'h00, rd);
					mIfr[1:0] = 2'b00;
				end
				1: begin
					access(1'b1, `VIA_RS_ORB, 8'h00, rd);
					mIfr[4:3] = 2'b00;
				end
				2: begin
					v = $random(seed);
					write(`VIA_RS_IFR, v);
					mIfr = mIfr & ~v[6:0];
				end
				default: ;
			endcase
			access(1'b1, `VIA_RS_IFR, 8'h00, rd);
			checkByte("IFR", rd, ifrRead());
			access(1'b1, `VIA_RS_IER, 8'h00, rd);
			checkByte("IER", rd, {1'b1, mIer});
			checkIrq(nIrq, ~|(mIfr & mIer));
		end

		// Input latching on rising CA1 and CB1
		write(`VIA_RS_IER, 8'h7F);
		write(`VIA_RS_PCR, 8'h11);
		write(`VIA_RS_ACR, 8'h03);
		write(`VIA_RS_DDRB, 8'h00);
		lines[0] = 1'b0;
		lines[2] = 1'b0;
		idle(1'b1);
		v = $random(seed);
		pinA = v;
		pinB = ~v;
		lines[0] = 1'b1;
		lines[2] = 1'b1;
		idle(1'b1);
		pinA = ~v;
		pinB = v;
		access(1'b1, `VIA_RS_ORA, 8'h00, rd);
		checkByte("ORA latched", rd, v);
		access(1'b1, `VIA_RS_ORB, 8'h00, rd);
		checkByte("ORB latched", rd, ~v);
		write(`VIA_RS_ACR, 8'h00);
		write(`VIA_RS_IFR, 8'h7F);

		// Timer 1 one-shot
		write(`VIA_RS_IER, 8'hC0);
		n = 2 + $unsigned($random(seed)) % 8;
		write(`VIA_RS_T1LL, 8'(n));
		write(`VIA_RS_T1CH, 8'h00);
		waitTimerFlag("T1 one-shot flag", n);
		access(1'b1, `VIA_RS_T1CL, 8'h00, rd);
		checkIrq(nIrq, 1'b1);
		repeat (2 * n + 10) begin
			idle(1'b1);
			checkIrq(nIrq, 1'b1);
		end

		// Timer 1 free-run with PB7 output
		n = 2 + $unsigned($random(seed)) % 8;
		write(`VIA_RS_T1LL, 8'(n));
		write(`VIA_RS_ACR, 8'hC0);
		write(`VIA_RS_T1CH, 8'h00);
		// One-shot expiry left PB7 high and a free-run load keeps it
		pb7 = 1'b1;
		checkByte("portBOut bit 7", {portBOut[7], 7'd0}, {pb7, 7'd0});
		checkByte("portBDir", {portBDir[7], 7'd0}, 8'h80);
		repeat (3) begin
			waitTimerFlag("T1 free-run flag", n);
			pb7 = ~pb7;
			checkByte("portBOut bit 7", {portBOut[7], 7'd0}, {pb7, 7'd0});
			access(1'b1, `VIA_RS_T1CL, 8'h00, rd);
			checkIrq(nIrq, 1'b1);
		end
		write(`VIA_RS_ACR, 8'h00);

		// Timer 2 one-shot
		write(`VIA_RS_IER, 8'h40);
		write(`VIA_RS_IER, 8'hA0);
		n = 2 + $unsigned($random(seed)) % 8;
		write(`VIA_RS_T2CL, 8'(n));
		write(`VIA_RS_T2CH, 8'h00);
		waitTimerFlag("T2 one-shot flag", n);
		access(1'b1, `VIA_RS_T2CL, 8'h00, rd);
		checkIrq(nIrq, 1'b1);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/viaPkg.sv
rtl/viaRegisterFile.sv
rtl/viaTimers.sv
rtl/viaInterrupts.sv
rtl/via6522.sv
dv/tbVia.sv

// ==== Makefile ====
# Verilator flow for the VIA

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module via6522

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tbVia -Mdir obj_dir
	@out=$$(./obj_dir/VtbVia); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
